// ==== tpuDataPkg.sv ====
/*
 * Datapath definitions for the matrix engine
 * Array size, operand widths and the value types that travel between stages
 */
`default_nettype none

package tpuDataPkg;

    // Array geometry
    localparam int ArrayDim    = 4;
    localparam int RowIdxWidth = $clog2(ArrayDim);
    // Row index in the high bits, column index in the low bits
    localparam int AddrWidth   = 2 * RowIdxWidth;

    // Operand and result widths
    localparam int WeightWidth = 8;
    localparam int ActWidth    = 7;
    // Product width plus 2 guard bits for the 4-deep column sum
    localparam int PsumWidth   = WeightWidth + ActWidth + 2;
    localparam int ResultWidth = 7;
    localparam int ResultMax   = (1 << ResultWidth) - 1;

    typedef logic signed [WeightWidth-1:0] weightT;
    typedef logic        [ActWidth-1:0]    actT;
    typedef logic signed [PsumWidth-1:0]   psumT;
    typedef logic        [RowIdxWidth-1:0] rowIdxT;
    typedef logic        [AddrWidth-1:0]   addrT;
    typedef logic        [ResultWidth-1:0] resultT;

endpackage

`default_nettype wire

// ==== tpuCtrlPkg.sv ====
/*
 * Control definitions for the run sequencer
 * State encoding and the length of each run phase
 */
`default_nettype none

package tpuCtrlPkg;

    import tpuDataPkg::*;

    typedef enum logic [2:0] {Idle, Preload, Stream, Drain, Finish} seqStateT;

    // One weight row per preload cycle, one activation vector per stream cycle
    localparam int PreloadCycles = ArrayDim;
    localparam int StreamCycles  = ArrayDim;
    // Covers the skew, the array depth and the deskew
    localparam int DrainCycles   = 3 * ArrayDim;

    // Phase counter must reach the longest phase
    localparam int PhaseWidth = $clog2(DrainCycles + 1);
    typedef logic [PhaseWidth-1:0] phaseT;

endpackage

`default_nettype wire

// ==== operandStore.sv ====
/*
 * Operand storage
 * Host writes weights and activations one element at a time,
 * the engine reads one full row of each per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module operandStore
    import tpuDataPkg::*;
(
    input  logic                   clk,
    input  logic                   wrEn,
    input  logic                   wrIsWeight,
    input  addrT                   wrAddr,
    input  logic [WeightWidth-1:0] wrData,
    input  rowIdxT                 rowSel,
    output weightT                 weightRow [ArrayDim],
    output actT                    actRow    [ArrayDim]
);

    // Register files, row by column
    weightT weightMem [ArrayDim][ArrayDim];
    actT    actMem    [ArrayDim][ArrayDim];

    rowIdxT wrRow;
    rowIdxT wrCol;

    // Split the host address
    assign wrRow = wrAddr[AddrWidth-1 -: RowIdxWidth];
    assign wrCol = wrAddr[RowIdxWidth-1:0];

    always_ff @(posedge clk) begin
        if (wrEn && wrIsWeight) begin
            weightMem[wrRow][wrCol] <= weightT'(wrData);
        end
        if (wrEn && !wrIsWeight) begin
            // Activations use the low bits only
            actMem[wrRow][wrCol] <= wrData[ActWidth-1:0];
        end
    end

    // Combinational row read
    for (genvar c = 0; c < ArrayDim; c++) begin : gRead
        assign weightRow[c] = weightMem[rowSel][c];
        assign actRow[c]    = actMem[rowSel][c];
    end

endmodule

`default_nettype wire

// ==== skewFeeder.sv ====
/*
 * Skewed activation feed
 * Lane r is delayed by r cycles so the rows enter the array as a diagonal
 */
`timescale 1ns/1ps
`default_nettype none

module skewFeeder
    import tpuDataPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  actT                 actRow    [ArrayDim],
    input  logic                feedValid,
    output actT                 laneAct   [ArrayDim],
    output logic [ArrayDim-1:0] laneValid
);

    for (genvar r = 0; r < ArrayDim; r++) begin : gLane
        if (r == 0) begin : gDirect
            // First lane goes straight in
            assign laneAct[r]   = actRow[r];
            assign laneValid[r] = feedValid;
        end else begin : gDelay
            actT        actPipe [r];
            logic [r-1:0] vldPipe;

            // Payload chain
            always_ff @(posedge clk) begin
                actPipe[0] <= actRow[r];
                for (int k = 1; k < r; k++) begin
                    actPipe[k] <= actPipe[k-1];
                end
            end

            // Valid bits travel alongside
            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    vldPipe <= '0;
                end else begin
                    vldPipe[0] <= feedValid;
                    for (int k = 1; k < r; k++) begin
                        vldPipe[k] <= vldPipe[k-1];
                    end
                end
            end

            assign laneAct[r]   = actPipe[r-1];
            assign laneValid[r] = vldPipe[r-1];
        end
    end

endmodule

`default_nettype wire

// ==== macArray.sv ====
/*
 * Weight-stationary systolic array
 * Weights shift down during preload, activations move right,
 * partial sums move down and leave at the bottom row
 */
`timescale 1ns/1ps
`default_nettype none

module macArray
    import tpuDataPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                loadWeight,
    input  weightT              weightRow [ArrayDim],
    input  actT                 laneAct   [ArrayDim],
    input  logic [ArrayDim-1:0] laneValid,
    output psumT                colSum    [ArrayDim],
    output logic [ArrayDim-1:0] colValid
);

    // Stationary weights
    weightT wReg [ArrayDim][ArrayDim];

    // Rightward activation links, the last column has no neighbour
    actT  aNet    [ArrayDim][ArrayDim-1];
    logic aVldNet [ArrayDim][ArrayDim-1];
    // Downward partial-sum links
    psumT sNet    [ArrayDim][ArrayDim];
    logic sVldNet [ArrayDim][ArrayDim];

    // ==================================================
    // Weight preload
    // ==================================================
    always_ff @(posedge clk) begin
        if (loadWeight) begin
            for (int c = 0; c < ArrayDim; c++) begin
                wReg[0][c] <= weightRow[c];
                for (int r = 1; r < ArrayDim; r++) begin
                    wReg[r][c] <= wReg[r-1][c];
                end
            end
        end
    end

    // ==================================================
    // MAC cells
    // ==================================================
    for (genvar r = 0; r < ArrayDim; r++) begin : gRow
        for (genvar c = 0; c < ArrayDim; c++) begin : gCol
            actT  aIn;
            logic aInVld;
            psumT sIn;
            logic sInVld;
            psumT prod;
            psumT sQ;
            logic sVldQ;

            // Activation from the feeder or the left neighbour
            if (c == 0) begin : gLeft
                assign aIn    = laneAct[r];
                assign aInVld = laneValid[r];
            end else begin : gInner
                assign aIn    = aNet[r][c-1];
                assign aInVld = aVldNet[r][c-1];
            end

            // Top row starts from zero
            if (r == 0) begin : gTop
                assign sIn    = '0;
                assign sInVld = 1'b1;
            end else begin : gBelow
                assign sIn    = sNet[r-1][c];
                assign sInVld = sVldNet[r-1][c];
            end

            // Signed weight times zero-extended activation
            assign prod = psumT'(wReg[r][c]) * psumT'({1'b0, aIn});

            always_ff @(posedge clk) begin
                sQ <= sIn + prod;
            end

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    sVldQ <= 1'b0;
                end else begin
                    sVldQ <= aInVld && sInVld;
                end
            end

            assign sNet[r][c]    = sQ;
            assign sVldNet[r][c] = sVldQ;

            if (c < ArrayDim - 1) begin : gPass
                actT  aQ;
                logic aVldQ;

                always_ff @(posedge clk) begin
                    aQ <= aIn;
                end

                always_ff @(posedge clk or posedge rst) begin
                    if (rst) begin
                        aVldQ <= 1'b0;
                    end else begin
                        aVldQ <= aInVld;
                    end
                end

                assign aNet[r][c]    = aQ;
                assign aVldNet[r][c] = aVldQ;
            end
        end
    end

    // Bottom row feeds the output stage
    for (genvar c = 0; c < ArrayDim; c++) begin : gOut
        assign colSum[c]   = sNet[ArrayDim-1][c];
        assign colValid[c] = sVldNet[ArrayDim-1][c];
    end

endmodule

`default_nettype wire

// ==== outputStage.sv ====
/*
 * Output path and unified buffer
 * Realigns the column sums, applies ReLU with 7-bit saturation
 * and stores one result row per aligned wavefront
 */
`timescale 1ns/1ps
`default_nettype none

module outputStage
    import tpuDataPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  psumT                colSum   [ArrayDim],
    input  logic [ArrayDim-1:0] colValid,
    input  addrT                rdAddr,
    output resultT              rdData
);

    psumT                aligned [ArrayDim];
    logic [ArrayDim-1:0] alignedVld;
    logic                ubWrEn;
    rowIdxT              wrRow;
    resultT              ubuf [ArrayDim][ArrayDim];

    // ReLU, then clip at the top of the result range
    function automatic resultT clampRelu(input psumT s);
        if (s < 0) begin
            return '0;
        end else if (s > psumT'(ResultMax)) begin
            return resultT'(ResultMax);
        end
        return s[ResultWidth-1:0];
    endfunction

    // ==================================================
    // Deskew, column j waits ArrayDim-1-j cycles
    // ==================================================
    for (genvar c = 0; c < ArrayDim; c++) begin : gDeskew
        localparam int Depth = ArrayDim - 1 - c;
        if (Depth == 0) begin : gDirect
            assign aligned[c]    = colSum[c];
            assign alignedVld[c] = colValid[c];
        end else begin : gDelay
            psumT             dly [Depth];
            logic [Depth-1:0] dlyVld;

            always_ff @(posedge clk) begin
                dly[0] <= colSum[c];
                for (int k = 1; k < Depth; k++) begin
                    dly[k] <= dly[k-1];
                end
            end

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    dlyVld <= '0;
                end else begin
                    dlyVld[0] <= colValid[c];
                    for (int k = 1; k < Depth; k++) begin
                        dlyVld[k] <= dlyVld[k-1];
                    end
                end
            end

            assign aligned[c]    = dly[Depth-1];
            assign alignedVld[c] = dlyVld[Depth-1];
        end
    end

    // Whole row present
    assign ubWrEn = &alignedVld;

    // ==================================================
    // Unified buffer
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrRow <= '0;
        end else if (ubWrEn) begin
            // Wraps so every run lands on rows 0..3
            wrRow <= wrRow + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ubWrEn) begin
            for (int c = 0; c < ArrayDim; c++) begin
                ubuf[wrRow][c] <= clampRelu(aligned[c]);
            end
        end
    end

    // Registered host read port
    always_ff @(posedge clk) begin
        rdData <= ubuf[rdAddr[AddrWidth-1 -: RowIdxWidth]][rdAddr[RowIdxWidth-1:0]];
    end

endmodule

`default_nettype wire

// ==== tpuSequencer.sv ====
/*
 * Run sequencer
 * FSM stepping through weight preload, activation stream, drain and done
 */
`timescale 1ns/1ps
`default_nettype none

module tpuSequencer
    import tpuDataPkg::*;
    import tpuCtrlPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    output rowIdxT rowSel,
    output logic   loadWeight,
    output logic   feedValid,
    output logic   done
);

    seqStateT state;
    phaseT    cnt;

    // ==================================================
    // FSM with a single phase counter
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= Idle;
            cnt   <= '0;
        end else begin
            case (state)
                Idle: begin
                    // Start only honoured here
                    if (start) begin
                        state <= Preload;
                        cnt   <= '0;
                    end
                end
                Preload: begin
                    if (cnt == phaseT'(PreloadCycles - 1)) begin
                        state <= Stream;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                Stream: begin
                    if (cnt == phaseT'(StreamCycles - 1)) begin
                        state <= Drain;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                Drain: begin
                    // Wait for the last row to reach the buffer
                    if (cnt == phaseT'(DrainCycles - 1)) begin
                        state <= Finish;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                Finish: begin
                    state <= Idle;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // Weight rows go in bottom first, activations top first
    assign rowSel = (state == Preload) ? rowIdxT'(ArrayDim - 1) - rowIdxT'(cnt)
                                       : rowIdxT'(cnt);

    assign loadWeight = (state == Preload);
    assign feedValid  = (state == Stream);
    assign done       = (state == Finish);

endmodule

`default_nettype wire

// ==== tpuTop.sv ====
/*
 * Matrix engine top level
 * Operand store and sequencer drive the feed, array and output stages
 */
`timescale 1ns/1ps
`default_nettype none

module tpuTop
    import tpuDataPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wrEn,
    input  logic                   wrIsWeight,
    input  addrT                   wrAddr,
    input  logic [WeightWidth-1:0] wrData,
    input  logic                   start,
    output logic                   done,
    input  addrT                   rdAddr,
    output resultT                 rdData
);

    // Sequencer controls
    rowIdxT rowSel;
    logic   loadWeight;
    logic   feedValid;

    // Operand rows
    weightT weightRow [ArrayDim];
    actT    actRow    [ArrayDim];

    // Skewed lanes into the array
    actT                 laneAct [ArrayDim];
    logic [ArrayDim-1:0] laneValid;

    // Column sums out of the array
    psumT                colSum [ArrayDim];
    logic [ArrayDim-1:0] colValid;

    operandStore u_operandStore (
        .clk        (clk),
        .wrEn       (wrEn),
        .wrIsWeight (wrIsWeight),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .rowSel     (rowSel),
        .weightRow  (weightRow),
        .actRow     (actRow)
    );

    tpuSequencer u_tpuSequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rowSel     (rowSel),
        .loadWeight (loadWeight),
        .feedValid  (feedValid),
        .done       (done)
    );

    skewFeeder u_skewFeeder (
        .clk       (clk),
        .rst       (rst),
        .actRow    (actRow),
        .feedValid (feedValid),
        .laneAct   (laneAct),
        .laneValid (laneValid)
    );

    macArray u_macArray (
        .clk        (clk),
        .rst        (rst),
        .loadWeight (loadWeight),
        .weightRow  (weightRow),
        .laneAct    (laneAct),
        .laneValid  (laneValid),
        .colSum     (colSum),
        .colValid   (colValid)
    );

    outputStage u_outputStage (
        .clk      (clk),
        .rst      (rst),
        .colSum   (colSum),
        .colValid (colValid),
        .rdAddr   (rdAddr),
        .rdData   (rdData)
    );

endmodule

`default_nettype wire

// ==== tpuClockGen.sv ====
/*
 * Testbench clock and reset source
 * 8 ns clock, reset held high for the first 4 rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module tpuClockGen (
    output logic clk,
    output logic rst
);

    localparam int HalfPeriodNs = 4;
    localparam int ResetCycles  = 4;

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(HalfPeriodNs) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tpu_assertions.sv ====
/*
 * Control assertions for the matrix engine
 * Bound into the top level, watches done and the read port
 */
`timescale 1ns/1ps
`default_nettype none

module tpu_assertions
    import tpuDataPkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   done,
    input resultT rdData
);

    // Set once the buffer holds a full run of results
    logic seenDone;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seenDone <= 1'b0;
        end else if (done) begin
            seenDone <= 1'b1;
        end
    end

    // done is a single-cycle strobe
    doneIsPulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for two cycles");

    // No completion while in reset
    doneLowInReset: assert property (@(posedge clk) rst |-> !done)
        else $error("done high during reset");

    // Buffer fully written after the first run
    rdDataKnown: assert property (@(posedge clk) disable iff (rst)
        seenDone |-> !$isunknown(rdData))
        else $error("rdData unknown after first done");

endmodule

`default_nettype wire

// ==== tpuTb.sv ====
/*
 * Testbench for the matrix engine
 * Loads operands, runs the engine and checks the read-back buffer
 * against a reference model of the clamped matrix product
 */
`timescale 1ns/1ps
`default_nettype none

module tpuTb
    import tpuDataPkg::*;
;

    // ==================================================
    // Run length and watchdog budget
    // ==================================================
    localparam int NumRuns     = 4;
    localparam int RunCycles   = 40;
    localparam int ClkPeriodNs = 8;
    // Weight pass, activation pass and read pass per run
    localparam int HostCycles  = 3 * ArrayDim * ArrayDim + 8;
    localparam int MarginNs    = 400;
    localparam int WatchdogNs  = NumRuns * (RunCycles + HostCycles) * ClkPeriodNs + MarginNs;

    logic                   clk;
    logic                   rst;
    logic                   wrEn;
    logic                   wrIsWeight;
    addrT                   wrAddr;
    logic [WeightWidth-1:0] wrData;
    logic                   start;
    logic                   done;
    addrT                   rdAddr;
    resultT                 rdData;

    // Operand images and expected results
    int wMat   [ArrayDim][ArrayDim];
    int aMat   [ArrayDim][ArrayDim];
    int expMat [ArrayDim][ArrayDim];

    // Outstanding reads for the compare process
    logic [31:0] expQ [$];
    string       nameQ [$];
    logic        rdReq;
    logic        rdReqD;
    int          doneCount;

    logic [31:0] lfsrState = 32'h014e_ff5b;

    tpuClockGen u_clockGen (
        .clk (clk),
        .rst (rst)
    );

    tpuTop u_dut (
        .clk        (clk),
        .rst        (rst),
        .wrEn       (wrEn),
        .wrIsWeight (wrIsWeight),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .start      (start),
        .done       (done),
        .rdAddr     (rdAddr),
        .rdData     (rdData)
    );

    bind tpuTop tpu_assertions u_tpuAssertions (
        .clk    (clk),
        .rst    (rst),
        .done   (done),
        .rdData (rdData)
    );

    // ==================================================
    // Random source and reference model
    // ==================================================
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic int randWeight();
        logic signed [7:0] b;
        b = 8'(randBits(8));
        return int'(b);
    endfunction

    // Clamp of the column sum to 0..127
    function automatic int refResult(input int t, input int j);
        int sum;
        sum = 0;
        for (int r = 0; r < ArrayDim; r++) begin
            sum += aMat[t][r] * wMat[r][j];
        end
        if (sum < 0) begin
            return 0;
        end else if (sum > 127) begin
            return 127;
        end
        return sum;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] expV, input logic [31:0] actV);
        if (actV !== expV) begin
            $display("ERR time=%0t signal=%s expected=%0d actual=%0d", $time, name, expV, actV);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // ==================================================
    // Host-side tasks
    // ==================================================
    task automatic writeMatrix(input logic isWeight);
        for (int t = 0; t < ArrayDim; t++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                @(posedge clk);
                wrEn       <= 1'b1;
                wrIsWeight <= isWeight;
                wrAddr     <= addrT'(t * ArrayDim + j);
                wrData     <= isWeight ? 8'(wMat[t][j]) : 8'(aMat[t][j]);
            end
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic fillActs(input bit nonZero);
        for (int t = 0; t < ArrayDim; t++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                aMat[t][j] = int'(randBits(7));
                if (nonZero && aMat[t][j] == 0) begin
                    aMat[t][j] = 1;
                end
            end
        end
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Polls done on each rising edge
    task automatic waitDone();
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
    endtask

    task automatic readBack();
        for (int t = 0; t < ArrayDim; t++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                @(posedge clk);
                rdAddr <= addrT'(t * ArrayDim + j);
                rdReq  <= 1'b1;
                expQ.push_back(expMat[t][j]);
                nameQ.push_back($sformatf("rdData[%0d][%0d]", t, j));
            end
        end
        @(posedge clk);
        rdReq <= 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic expectReference();
        for (int t = 0; t < ArrayDim; t++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                expMat[t][j] = refResult(t, j);
            end
        end
    endtask

    // ==================================================
    // Compare process with rdData one cycle behind rdAddr
    // ==================================================
    always @(posedge clk) begin
        rdReqD <= rdReq;
        if (rdReqD) begin
            checkEq(nameQ.pop_front(), expQ.pop_front(), 32'(rdData));
        end
    end

    always @(posedge clk) begin
        if (done === 1'b1) begin
            doneCount <= doneCount + 1;
        end
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout after %0d ns, done never arrived", WatchdogNs);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        wrEn       = 1'b0;
        wrIsWeight = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        start      = 1'b0;
        rdAddr     = '0;
        rdReq      = 1'b0;
        rdReqD     = 1'b0;
        doneCount  = 0;
        wait (rst == 1'b0);

        // Quiet after reset
        repeat (8) begin
            @(posedge clk);
            checkEq("done", 0, 32'(done));
        end

        // Identity weights pass activations through
        for (int r = 0; r < ArrayDim; r++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                wMat[r][j] = (r == j) ? 1 : 0;
            end
        end
        fillActs(1'b0);
        writeMatrix(1'b1);
        writeMatrix(1'b0);
        for (int t = 0; t < ArrayDim; t++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                expMat[t][j] = aMat[t][j];
            end
        end
        pulseStart();
        waitDone();
        readBack();

        // All weights in -128..-1 so every result clamps to zero
        for (int r = 0; r < ArrayDim; r++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                wMat[r][j] = -(1 + int'(randBits(7)));
                expMat[r][j] = 0;
            end
        end
        fillActs(1'b1);
        writeMatrix(1'b1);
        writeMatrix(1'b0);
        pulseStart();
        waitDone();
        readBack();

        // Random signed weights with clamping on both ends
        for (int r = 0; r < ArrayDim; r++) begin
            for (int j = 0; j < ArrayDim; j++) begin
                wMat[r][j] = randWeight();
            end
        end
        fillActs(1'b0);
        writeMatrix(1'b1);
        writeMatrix(1'b0);
        expectReference();
        pulseStart();
        waitDone();
        readBack();

        // New activations on the stationary weights and an extra start while busy
        fillActs(1'b0);
        writeMatrix(1'b0);
        expectReference();
        pulseStart();
        repeat (3) @(posedge clk);
        pulseStart();
        waitDone();
        readBack();
        repeat (RunCycles) @(posedge clk);
        checkEq("doneCount", NumRuns, 32'(doneCount));

        if (expQ.size() != 0) begin
            $display("Run ended with %0d read-back compares outstanding", expQ.size());
            $display("SOME TESTS FAILED");
            $fatal(1, "compares outstanding");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
tpuDataPkg.sv
tpuCtrlPkg.sv
operandStore.sv
skewFeeder.sv
macArray.sv
outputStage.sv
tpuSequencer.sv
tpuTop.sv
tpuClockGen.sv
tpu_assertions.sv
tpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the matrix engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module tpuTb \
    -f filelist.f -o tpuSim > "$LOG" 2>&1 \
    && ./obj_dir/tpuSim >> "$LOG" 2>&1
cat "$LOG"

grep -q "SOME TESTS FAILED" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "ALL TESTS PASSED" "$LOG" || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
